/* bench/cpu_testdata.txt */
# kind, then two hex columns: word or data address, then value
# P program word, D data preload, E expected data word, F done word and marker
P 00 04011234
P 01 080100F0
P 02 0C140000
P 03 4C010010
P 04 0C940000
P 05 4C010011
P 06 0D11FF00
P 07 4C010012
P 08 0D940000
P 09 4C010013
P 0A 0E140000
P 0B 4C010014
P 0C 0E8100FF
P 0D 4C010015
P 0E 0F110000
P 0F 4C010016
P 10 0F110001
P 11 4C010017
P 12 0F110002
P 13 4C010018
P 14 0F110003
P 15 4C010019
P 16 0F110004
P 17 4C01001A
P 18 0F110005
P 19 4C01001B
P 1A 0F110006
P 1B 4C01001C
P 1C 0F110007
P 1D 4C01001D
P 1E 10210010
P 1F 14C20000
P 20 1A580000
P 21 5801001E
P 22 24010020
P 23 04110101
P 24 4401001F
P 25 1C010028
P 26 4C010021
P 27 4C010022
P 28 48010023
P 29 1401600D
P 2A 5401003F
P 2B 1C01002B
P 2C 00000000
P 2D 00000000
P 2E 00000000
P 2F 00000000
P 30 00000000
D 20 0BAD0000
D 21 5A5A0021
D 22 5A5A0022
D 23 11110023
D 3F 00000000
E 10 00001324
E 11 00001144
E 12 0000FF34
E 13 00000030
E 14 000012C4
E 15 FFFFFF00
E 16 0000091A
E 17 0000048D
E 18 00000123
E 19 00000012
E 1A 00002468
E 1B 000048D0
E 1C 00012340
E 1D 00123400
E 1E FFFFEFCC
E 1F 0BAD0101
E 21 5A5A0021
E 22 5A5A0022
E 23 000000F0
F 3F 0000600D

/* project.f */
hdl/cpu_pkg.sv
hdl/insn_decoder.sv
hdl/alu.sv
hdl/dual_port_ram.sv
hdl/cpu_pipeline.sv
hdl/host_ctrl_regs.sv
hdl/cpu_system.sv
bench/tb_cpu_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_system
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_cpu_system.sv */
`timescale 1ns/1ps

module tb_cpu_system;

    localparam int PMEM_AW = 8;
    localparam int DMEM_AW = 8;
    localparam int CLK_PERIOD = 20;
    localparam int ACK_TIMEOUT = 16;
    localparam int DONE_POLLS = 500;

    logic clk;
    logic rst;
    cpu_pkg::wb_req_t wb_req;
    cpu_pkg::wb_rsp_t wb_rsp;

    int errors;
    int timeouts;

    // test data file contents
    int prog_addr_q[$];
    cpu_pkg::insn_t prog_word_q[$];
    int pre_addr_q[$];
    cpu_pkg::data_t pre_val_q[$];
    int exp_addr_q[$];
    cpu_pkg::data_t exp_val_q[$];
    int done_addr;
    cpu_pkg::data_t done_marker;

    cpu_system #(
        .PMEM_AW (PMEM_AW),
        .DMEM_AW (DMEM_AW)
    ) dut_i (
        .clk  (clk),
        .rst  (rst),
        .wb_i (wb_req),
        .wb_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // region in the top two bits, word offset below
    function automatic logic [11:0] host_adr(input logic [1:0] region, input int offset);
        return {region, offset[9:0]};
    endfunction

    task automatic check_data(input string name, input cpu_pkg::data_t expected,
                              input cpu_pkg::data_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_insn(input string name, input cpu_pkg::insn_t expected,
                              input cpu_pkg::insn_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_testdata();
        int fd;
        int n;
        string line;
        string kind;
        logic [31:0] addr;
        logic [31:0] value;
        fd = $fopen("bench/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/cpu_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %h %h", kind, addr, value);
            // comment lines never match a kind letter
            if (n == 3) begin
                if (kind == "P") begin
                    prog_addr_q.push_back(int'(addr));
                    prog_word_q.push_back(value);
                end else if (kind == "D") begin
                    pre_addr_q.push_back(int'(addr));
                    pre_val_q.push_back(value);
                end else if (kind == "E") begin
                    exp_addr_q.push_back(int'(addr));
                    exp_val_q.push_back(value);
                end else if (kind == "F") begin
                    done_addr = int'(addr);
                    done_marker = value;
                end
            end
        end
        $fclose(fd);
    endtask

    // one check per falling edge after the drive edge
    task automatic wait_ack(input logic [11:0] adr);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            $display("host cycle to address %h got no ack", adr);
            timeouts++;
        end
    endtask

    task automatic end_cycle();
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input cpu_pkg::data_t dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wait_ack(adr);
        end_cycle();
    endtask

    task automatic wb_read(input logic [11:0] adr, output cpu_pkg::data_t dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = 1'b0;
        wb_req.adr = adr;
        wait_ack(adr);
        dat = wb_rsp.dat;
        end_cycle();
    endtask

    task automatic load_program();
        cpu_pkg::data_t rd;
        foreach (prog_addr_q[i]) begin
            wb_write(host_adr(cpu_pkg::REGION_PMEM, prog_addr_q[i]), prog_word_q[i]);
        end
        foreach (prog_addr_q[i]) begin
            wb_read(host_adr(cpu_pkg::REGION_PMEM, prog_addr_q[i]), rd);
            check_insn($sformatf("pmem[%0h] readback", prog_addr_q[i]), prog_word_q[i],
                       cpu_pkg::insn_t'(rd));
        end
    endtask

    // preloads go out in a shuffled order
    task automatic preload_data();
        int order[$];
        int tmp;
        int j;
        foreach (pre_addr_q[i]) begin
            order.push_back(i);
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            wb_write(host_adr(cpu_pkg::REGION_DMEM, pre_addr_q[order[k]]),
                     pre_val_q[order[k]]);
        end
    endtask

    task automatic wait_done();
        cpu_pkg::data_t rd;
        int polls;
        polls = 0;
        do begin
            wb_read(host_adr(cpu_pkg::REGION_DMEM, done_addr), rd);
            polls++;
        end while (rd !== done_marker && polls < DONE_POLLS);
        if (rd !== done_marker) begin
            $display("program never wrote the done marker");
            timeouts++;
        end
    endtask

    initial begin
        cpu_pkg::data_t rd;
        cpu_pkg::data_t cycles_first;
        cpu_pkg::data_t cycles_second;
        errors = 0;
        timeouts = 0;
        done_addr = -1;
        done_marker = '0;
        rst = 1'b1;
        wb_req = '0;
        void'($urandom(34855));
        read_testdata();
        if (prog_addr_q.size() == 0 || done_addr < 0) begin
            $display("test data has no program or no done word");
            errors++;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wb_read(host_adr(cpu_pkg::REGION_REGS, cpu_pkg::REG_CTRL), rd);
        check_data("ctrl after reset", '0, rd);
        load_program();
        preload_data();

        // start the core and wait for the last store
        wb_write(host_adr(cpu_pkg::REGION_REGS, cpu_pkg::REG_CTRL), 32'h1);
        wait_done();
        wb_write(host_adr(cpu_pkg::REGION_REGS, cpu_pkg::REG_CTRL), 32'h0);

        wb_read(host_adr(cpu_pkg::REGION_REGS, cpu_pkg::REG_CYCLES), cycles_first);
        wb_read(host_adr(cpu_pkg::REGION_REGS, cpu_pkg::REG_CYCLES), cycles_second);
        if (cycles_first == '0) begin
            $display("cycle counter stayed at zero");
            errors++;
        end
        check_data("cycles after stop", cycles_first, cycles_second);
        wb_read(host_adr(cpu_pkg::REGION_DMEM, done_addr), rd);
        check_data("done word after stop", done_marker, rd);

        foreach (exp_addr_q[i]) begin
            wb_read(host_adr(cpu_pkg::REGION_DMEM, exp_addr_q[i]), rd);
            check_data($sformatf("dmem[%0h]", exp_addr_q[i]), exp_val_q[i], rd);
        end

        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* hdl/cpu_system.sv */
`timescale 1ns/1ps

module cpu_system #(
    parameter int PMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::wb_req_t  wb_i,
    output cpu_pkg::wb_rsp_t  wb_o
);

    logic core_rst;

    // core side, ram port A
    logic [PMEM_AW-1:0] prog_addr;
    cpu_pkg::insn_t prog_data;
    logic [DMEM_AW-1:0] data_addr;
    cpu_pkg::data_t data_wdata;
    logic data_we;
    cpu_pkg::data_t data_rdata;

    // host side, ram port B
    logic [PMEM_AW-1:0] pmem_addr;
    logic pmem_we;
    cpu_pkg::insn_t pmem_wdata;
    cpu_pkg::insn_t pmem_rdata;
    logic [DMEM_AW-1:0] dmem_addr;
    logic dmem_we;
    cpu_pkg::data_t dmem_wdata;
    cpu_pkg::data_t dmem_rdata;

    cpu_pipeline #(
        .PMEM_AW (PMEM_AW),
        .DMEM_AW (DMEM_AW)
    ) u_core (
        .clk          (clk),
        .rst          (core_rst),
        .prog_addr_o  (prog_addr),
        .prog_data_i  (prog_data),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_we_o    (data_we),
        .data_rdata_i (data_rdata)
    );

    host_ctrl_regs #(
        .PMEM_AW (PMEM_AW),
        .DMEM_AW (DMEM_AW)
    ) u_host_regs (
        .clk          (clk),
        .rst          (rst),
        .wb_i         (wb_i),
        .wb_o         (wb_o),
        .core_rst_o   (core_rst),
        .pmem_addr_o  (pmem_addr),
        .pmem_we_o    (pmem_we),
        .pmem_wdata_o (pmem_wdata),
        .pmem_rdata_i (pmem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_we_o    (dmem_we),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    // program memory, the core only reads it
    dual_port_ram #(
        .word_t (cpu_pkg::insn_t),
        .AW     (PMEM_AW)
    ) u_pmem (
        .clk       (clk),
        .a_addr_i  (prog_addr),
        .a_we_i    (1'b0),
        .a_wdata_i ('0),
        .a_rdata_o (prog_data),
        .b_addr_i  (pmem_addr),
        .b_we_i    (pmem_we),
        .b_wdata_i (pmem_wdata),
        .b_rdata_o (pmem_rdata)
    );

    dual_port_ram #(
        .word_t (cpu_pkg::data_t),
        .AW     (DMEM_AW)
    ) u_dmem (
        .clk       (clk),
        .a_addr_i  (data_addr),
        .a_we_i    (data_we),
        .a_wdata_i (data_wdata),
        .a_rdata_o (data_rdata),
        .b_addr_i  (dmem_addr),
        .b_we_i    (dmem_we),
        .b_wdata_i (dmem_wdata),
        .b_rdata_o (dmem_rdata)
    );

endmodule

/* hdl/host_ctrl_regs.sv */
`timescale 1ns/1ps

module host_ctrl_regs #(
    parameter int PMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::wb_req_t    wb_i,
    output cpu_pkg::wb_rsp_t    wb_o,
    output logic                core_rst_o,
    output logic [PMEM_AW-1:0]  pmem_addr_o,
    output logic                pmem_we_o,
    output cpu_pkg::insn_t      pmem_wdata_o,
    input  cpu_pkg::insn_t      pmem_rdata_i,
    output logic [DMEM_AW-1:0]  dmem_addr_o,
    output logic                dmem_we_o,
    output cpu_pkg::data_t      dmem_wdata_o,
    input  cpu_pkg::data_t      dmem_rdata_i
);

    logic req;
    logic [1:0] region;
    logic [1:0] region_ff;
    logic [cpu_pkg::HOST_REG_AW-1:0] reg_adr;
    logic ack_ff;
    logic run_ff;
    logic core_rst_ff;
    cpu_pkg::data_t cycles_ff;
    cpu_pkg::data_t reg_rdata;
    cpu_pkg::data_t reg_rdata_ff;

    // new request only while ack is low
    assign req = wb_i.cyc && wb_i.stb && !ack_ff;
    assign region = wb_i.adr[cpu_pkg::HOST_ADR_WIDTH-1 -: 2];
    assign reg_adr = wb_i.adr[cpu_pkg::HOST_REG_AW-1:0];

    // ram port B, write lands on the request edge
    assign pmem_addr_o = wb_i.adr[PMEM_AW-1:0];
    assign pmem_wdata_o = wb_i.dat;
    assign pmem_we_o = req && wb_i.we && region == cpu_pkg::REGION_PMEM;
    assign dmem_addr_o = wb_i.adr[DMEM_AW-1:0];
    assign dmem_wdata_o = wb_i.dat;
    assign dmem_we_o = req && wb_i.we && region == cpu_pkg::REGION_DMEM;

    always_comb begin
        reg_rdata = '0;
        case (reg_adr)
            cpu_pkg::REG_CTRL:   reg_rdata[cpu_pkg::CTRL_RUN_BIT] = run_ff;
            cpu_pkg::REG_CYCLES: reg_rdata = cycles_ff;
            default:             reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_ff <= 1'b0;
            run_ff <= 1'b0;
            cycles_ff <= '0;
            core_rst_ff <= 1'b1;
        end else begin
            ack_ff <= req;
            if (req && wb_i.we && region == cpu_pkg::REGION_REGS
                && reg_adr == cpu_pkg::REG_CTRL) begin
                run_ff <= wb_i.dat[cpu_pkg::CTRL_RUN_BIT];
            end
            if (run_ff) begin
                cycles_ff <= cycles_ff + 1'b1;
            end
            // core stays in reset while run is clear
            core_rst_ff <= !run_ff;
        end
    end

    // read source picked by the region seen with the request
    always_ff @(posedge clk) begin
        if (req) begin
            region_ff <= region;
            reg_rdata_ff <= reg_rdata;
        end
    end

    always_comb begin
        wb_o.ack = ack_ff;
        case (region_ff)
            cpu_pkg::REGION_PMEM: wb_o.dat = pmem_rdata_i;
            cpu_pkg::REGION_DMEM: wb_o.dat = dmem_rdata_i;
            cpu_pkg::REGION_REGS: wb_o.dat = reg_rdata_ff;
            default:              wb_o.dat = '0;
        endcase
    end

    assign core_rst_o = core_rst_ff;

endmodule

/* hdl/cpu_pipeline.sv */
`timescale 1ns/1ps

module cpu_pipeline #(
    parameter int PMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    output logic [PMEM_AW-1:0]  prog_addr_o,
    input  cpu_pkg::insn_t      prog_data_i,
    output logic [DMEM_AW-1:0]  data_addr_o,
    output cpu_pkg::data_t      data_wdata_o,
    output logic                data_we_o,
    input  cpu_pkg::data_t      data_rdata_i
);

    logic [cpu_pkg::PC_WIDTH-1:0] pc_ff;
    cpu_pkg::data_t gpr_ff [cpu_pkg::SEL_RA:cpu_pkg::SEL_SP];
    cpu_pkg::data_t rf [0:7];

    logic if_valid_ff;
    logic if_prev_stall_ff;
    cpu_pkg::insn_t if_prev_insn_ff;
    cpu_pkg::insn_t il_insn_ff;
    logic il_valid_ff;

    cpu_pkg::insn_fields_t dcd;
    logic stall;
    logic flush;
    logic bubble;
    logic [1:0] bubble_cnt_ff;

    cpu_pkg::dcd_ex_t dcd_ex_next;
    cpu_pkg::dcd_ex_t dcd_ex_ff;
    cpu_pkg::data_t ex_result;
    cpu_pkg::ex_mio_t ex_mio_ff;
    cpu_pkg::mio_wb_t mio_wb_ff;
    cpu_pkg::data_t wb_result;
    logic wb_we;

    // true when a later stage will write a register the decoded insn reads
    function automatic logic targets(input logic valid, input logic mem_write,
                                     input cpu_pkg::regsel_t d_sel,
                                     input cpu_pkg::insn_fields_t f);
        logic hit;
        hit = (d_sel == f.a_sel) || (!f.imm_en && d_sel == f.b_sel)
            || (f.mem_write && d_sel == f.d_sel);
        return valid && !mem_write && d_sel != cpu_pkg::SEL_R0 && hit;
    endfunction

    // fetch
    assign prog_addr_o = pc_ff[PMEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid_ff <= 1'b0;
            if_prev_stall_ff <= 1'b0;
            il_valid_ff <= 1'b0;
        end else begin
            // ram output in the first cycle is left over from reset
            if_valid_ff <= 1'b1;
            if_prev_stall_ff <= stall;
            if (!stall) begin
                il_valid_ff <= if_prev_stall_ff || if_valid_ff;
            end
        end
    end

    // the ram moves on during a stall, keep the word it gave first
    always_ff @(posedge clk) begin
        if (!if_prev_stall_ff) begin
            if_prev_insn_ff <= prog_data_i;
        end
        if (!stall) begin
            il_insn_ff <= if_prev_stall_ff ? if_prev_insn_ff : prog_data_i;
        end
    end

    // decode
    insn_decoder u_decoder (
        .insn_i   (il_insn_ff),
        .fields_o (dcd)
    );

    always_comb begin
        rf[cpu_pkg::SEL_R0] = '0;
        for (int i = cpu_pkg::SEL_RA; i <= cpu_pkg::SEL_SP; i++) begin
            rf[i] = gpr_ff[i];
        end
        rf[cpu_pkg::SEL_PC] = cpu_pkg::data_t'(pc_ff);
    end

    assign stall = il_valid_ff
        && (targets(dcd_ex_ff.valid, dcd_ex_ff.mem_write, dcd_ex_ff.d_sel, dcd)
         || targets(ex_mio_ff.valid, ex_mio_ff.mem_write, ex_mio_ff.d_sel, dcd)
         || targets(mio_wb_ff.valid, mio_wb_ff.mem_write, mio_wb_ff.d_sel, dcd));

    always_comb begin
        dcd_ex_next.valid = il_valid_ff && !stall && !bubble && !flush;
        dcd_ex_next.mem_read = dcd.mem_read;
        dcd_ex_next.mem_write = dcd.mem_write;
        dcd_ex_next.op_sel = dcd.op_sel;
        dcd_ex_next.d_sel = dcd.d_sel;
        dcd_ex_next.alu_a = rf[dcd.a_sel];
        // immediate is zero extended
        dcd_ex_next.alu_b = dcd.imm_en ? cpu_pkg::data_t'(dcd.imm) : rf[dcd.b_sel];
        dcd_ex_next.reg_d = rf[dcd.d_sel];
    end

    always_ff @(posedge clk) begin
        dcd_ex_ff <= dcd_ex_next;
        if (rst) begin
            dcd_ex_ff.valid <= 1'b0;
        end
    end

    // execute
    alu u_alu (
        .op_i     (dcd_ex_ff.op_sel),
        .a_i      (dcd_ex_ff.alu_a),
        .b_i      (dcd_ex_ff.alu_b),
        .result_o (ex_result)
    );

    always_ff @(posedge clk) begin
        ex_mio_ff.valid <= dcd_ex_ff.valid && !flush;
        ex_mio_ff.mem_read <= dcd_ex_ff.mem_read;
        ex_mio_ff.mem_write <= dcd_ex_ff.mem_write;
        ex_mio_ff.d_sel <= dcd_ex_ff.d_sel;
        ex_mio_ff.alu_r <= ex_result;
        ex_mio_ff.reg_d <= dcd_ex_ff.reg_d;
        if (rst) begin
            ex_mio_ff.valid <= 1'b0;
        end
    end

    // memory, address from alu and store data from D
    assign data_addr_o = ex_mio_ff.alu_r[DMEM_AW-1:0];
    assign data_wdata_o = ex_mio_ff.reg_d;
    assign data_we_o = ex_mio_ff.valid && ex_mio_ff.mem_write && !flush;

    always_ff @(posedge clk) begin
        mio_wb_ff.valid <= ex_mio_ff.valid && !flush;
        mio_wb_ff.mem_read <= ex_mio_ff.mem_read;
        mio_wb_ff.mem_write <= ex_mio_ff.mem_write;
        mio_wb_ff.d_sel <= ex_mio_ff.d_sel;
        mio_wb_ff.alu_r <= ex_mio_ff.alu_r;
        if (rst) begin
            mio_wb_ff.valid <= 1'b0;
        end
    end

    // writeback, load data arrives this cycle
    assign wb_result = mio_wb_ff.mem_read ? data_rdata_i : mio_wb_ff.alu_r;
    assign wb_we = mio_wb_ff.valid && !mio_wb_ff.mem_write;
    // pc write is a jump, younger stages are dropped
    assign flush = wb_we && mio_wb_ff.d_sel == cpu_pkg::SEL_PC;
    assign bubble = bubble_cnt_ff != 2'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = cpu_pkg::SEL_RA; i <= cpu_pkg::SEL_SP; i++) begin
                gpr_ff[i] <= '0;
            end
        end else if (wb_we && mio_wb_ff.d_sel != cpu_pkg::SEL_R0
                     && mio_wb_ff.d_sel != cpu_pkg::SEL_PC) begin
            gpr_ff[mio_wb_ff.d_sel] <= wb_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_ff <= '0;
        end else if (flush) begin
            pc_ff <= wb_result[cpu_pkg::PC_WIDTH-1:0];
        end else if (!stall) begin
            pc_ff <= pc_ff + 1'b1;
        end
    end

    // two stale words still reach decode after a jump
    always_ff @(posedge clk) begin
        if (rst) begin
            bubble_cnt_ff <= 2'd0;
        end else if (flush) begin
            bubble_cnt_ff <= 2'd2;
        end else if (bubble) begin
            bubble_cnt_ff <= bubble_cnt_ff - 2'd1;
        end
    end

endmodule

/* hdl/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
    parameter type word_t = logic [31:0],
    parameter int  AW = 8
) (
    input  logic          clk,
    input  logic [AW-1:0] a_addr_i,
    input  logic          a_we_i,
    input  word_t         a_wdata_i,
    output word_t         a_rdata_o,
    input  logic [AW-1:0] b_addr_i,
    input  logic          b_we_i,
    input  word_t         b_wdata_i,
    output word_t         b_rdata_o
);

    word_t mem [0:2**AW-1];

    // both ports read the old word on a write
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opsel_t op_i,
    input  cpu_pkg::data_t  a_i,
    input  cpu_pkg::data_t  b_i,
    output cpu_pkg::data_t  result_o
);

    // shift amount 1, 2, 4 or 8 from b[1:0]
    logic [3:0] shamt;

    always_comb begin
        shamt = 4'd1 << b_i[1:0];
        case (op_i)
            cpu_pkg::OP_ADD: result_o = a_i + b_i;
            cpu_pkg::OP_SUB: result_o = a_i - b_i;
            cpu_pkg::OP_OR:  result_o = a_i | b_i;
            cpu_pkg::OP_AND: result_o = a_i & b_i;
            cpu_pkg::OP_XOR: result_o = a_i ^ b_i;
            cpu_pkg::OP_NOT: result_o = ~b_i;
            // b[2] set shifts left
            cpu_pkg::OP_SHI: result_o = b_i[2] ? (a_i << shamt) : (a_i >> shamt);
            default:         result_o = '0;
        endcase
    end

endmodule

/* hdl/insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder (
    input  logic [cpu_pkg::INSN_WIDTH-1:0] insn_i,
    output cpu_pkg::insn_fields_t          fields_o
);

    // memory access flags
    assign fields_o.mem_write = insn_i[cpu_pkg::F_MEM_WRITE];
    assign fields_o.mem_read = insn_i[cpu_pkg::F_MEM_READ];

    // register and op selects
    assign fields_o.d_sel = insn_i[cpu_pkg::F_D_SEL +: cpu_pkg::REGSEL_WIDTH];
    assign fields_o.op_sel = insn_i[cpu_pkg::F_OP_SEL +: cpu_pkg::OPSEL_WIDTH];
    assign fields_o.a_sel = insn_i[cpu_pkg::F_A_SEL +: cpu_pkg::REGSEL_WIDTH];
    assign fields_o.b_sel = insn_i[cpu_pkg::F_B_SEL +: cpu_pkg::REGSEL_WIDTH];

    // immediate replaces B when enabled
    assign fields_o.imm_en = insn_i[cpu_pkg::F_IMM_EN];
    assign fields_o.imm = insn_i[cpu_pkg::F_IMM +: cpu_pkg::IMM_WIDTH];

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    localparam int INSN_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int PC_WIDTH = 16;
    localparam int IMM_WIDTH = 16;
    localparam int REGSEL_WIDTH = 3;
    localparam int OPSEL_WIDTH = 3;

    // instruction fields, lsb positions
    localparam int F_MEM_WRITE = 30;
    localparam int F_MEM_READ = 29;
    localparam int F_D_SEL = 26;
    localparam int F_OP_SEL = 23;
    localparam int F_A_SEL = 20;
    localparam int F_B_SEL = 17;
    localparam int F_IMM_EN = 16;
    localparam int F_IMM = 0;

    typedef logic [INSN_WIDTH-1:0] insn_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [REGSEL_WIDTH-1:0] regsel_t;
    typedef logic [OPSEL_WIDTH-1:0] opsel_t;

    // register selects, R0 reads as zero
    localparam regsel_t SEL_R0 = 3'd0;
    localparam regsel_t SEL_RA = 3'd1;
    localparam regsel_t SEL_RB = 3'd2;
    localparam regsel_t SEL_RC = 3'd3;
    localparam regsel_t SEL_RD = 3'd4;
    localparam regsel_t SEL_RE = 3'd5;
    localparam regsel_t SEL_SP = 3'd6;
    localparam regsel_t SEL_PC = 3'd7;

    localparam opsel_t OP_ADD = 3'd0;
    localparam opsel_t OP_SUB = 3'd1;
    localparam opsel_t OP_OR = 3'd2;
    localparam opsel_t OP_AND = 3'd3;
    localparam opsel_t OP_XOR = 3'd4;
    localparam opsel_t OP_NOT = 3'd5;
    localparam opsel_t OP_SHI = 3'd6;

    // host word address map, region in the top two bits
    localparam int HOST_ADR_WIDTH = 12;
    localparam int HOST_REG_AW = 10;
    localparam logic [1:0] REGION_PMEM = 2'd0;
    localparam logic [1:0] REGION_DMEM = 2'd1;
    localparam logic [1:0] REGION_REGS = 2'd2;
    localparam logic [HOST_REG_AW-1:0] REG_CTRL = 10'd0;
    localparam logic [HOST_REG_AW-1:0] REG_CYCLES = 10'd1;
    localparam int CTRL_RUN_BIT = 0;

    typedef struct packed {
        logic mem_write;
        logic mem_read;
        regsel_t d_sel;
        opsel_t op_sel;
        regsel_t a_sel;
        regsel_t b_sel;
        logic imm_en;
        logic [IMM_WIDTH-1:0] imm;
    } insn_fields_t;

    typedef struct packed {
        logic valid;
        logic mem_read;
        logic mem_write;
        opsel_t op_sel;
        regsel_t d_sel;
        data_t alu_a;
        data_t alu_b;
        data_t reg_d;
    } dcd_ex_t;

    typedef struct packed {
        logic valid;
        logic mem_read;
        logic mem_write;
        regsel_t d_sel;
        data_t alu_r;
        data_t reg_d;
    } ex_mio_t;

    typedef struct packed {
        logic valid;
        logic mem_read;
        logic mem_write;
        regsel_t d_sel;
        data_t alu_r;
    } mio_wb_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [HOST_ADR_WIDTH-1:0] adr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        data_t dat;
    } wb_rsp_t;

endpackage
